// ==== hw/ring_gw_settings.svh ====
// Build-time sizes for the ring gateway.
// Included by the package and by every RTL module that needs a width.
// Change the values here to resize the whole gateway at once.

`ifndef RING_GW_SETTINGS_SVH
`define RING_GW_SETTINGS_SVH

// Flit data word, payload plus destination in the first flit
`define RING_FLIT_WIDTH 32

// Destination field, taken from the top bits of a first flit
`define RING_DEST_WIDTH 5

// Default depth of the ring input buffer, in flits
`define GW_FIFO_DEPTH 4

`endif

// ==== hw/ring_gw_pkg.sv ====
// Shared types of the ring gateway.
// Modules take them with a wildcard import in the module header.

`include "ring_gw_settings.svh"

package ring_gw_pkg;

  // One data word of a flit
  typedef logic [`RING_FLIT_WIDTH-1:0] flit_data_t;

  // Node address, also the destination field of a first flit
  typedef logic [`RING_DEST_WIDTH-1:0] node_id_t;

  // Flit as it travels on a stream, last marks the packet end
  typedef struct packed {
    flit_data_t data;
    logic       last;
  } flit_t;

  // Arbiter states, which source owns the ring output
  typedef enum logic [1:0] {
    worm_idle,
    worm_ring,
    worm_local,
    worm_ext
  } worm_state_t;

  // Router states, where the current packet is steered
  typedef enum logic [1:0] {
    route_idle,
    route_local,
    route_pass
  } route_state_t;

endpackage

// ==== hw/flit_fifo.sv ====
// Flit buffer on the ring input of the gateway.
// Circular buffer with valid/ready on both sides. A stored flit shows on
// the output from the edge that wrote it. Push and pop may happen in the
// same cycle, also when the buffer is full.

`timescale 1ns/1ps
`include "ring_gw_settings.svh"

module flit_fifo import ring_gw_pkg::*; #(
  parameter int depth = `GW_FIFO_DEPTH
) (
  input  logic  clk,
  input  logic  rst,

  input  flit_t in_flit,
  input  logic  in_valid,
  output logic  in_ready,

  output flit_t out_flit,
  output logic  out_valid,
  input  logic  out_ready
);

  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);

  typedef logic [ptr_w-1:0] ptr_t;
  typedef logic [cnt_w-1:0] cnt_t;

  ////////////////////////////////////////////////////////////////////////////
  // Storage and pointers
  ////////////////////////////////////////////////////////////////////////////

  flit_t mem [depth];
  ptr_t  wr_ptr;
  ptr_t  rd_ptr;
  cnt_t  count;
  logic  push;
  logic  pop;
  logic  full;

  // Wrap at depth, which need not be a power of two
  function automatic ptr_t ptr_next(ptr_t p);
    if (p == ptr_t'(depth - 1)) begin
      return '0;
    end
    return p + ptr_t'(1);
  endfunction

  assign full      = (count == cnt_t'(depth));
  assign out_valid = (count != '0);
  assign out_flit  = mem[rd_ptr];

  // A pop frees a slot in the same cycle
  assign in_ready = !full || out_ready;
  assign push     = in_valid && in_ready;
  assign pop      = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_flit;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      // Occupancy holds when both or neither happen
      case ({push, pop})
        2'b10:   count <= count + cnt_t'(1);
        2'b01:   count <= count - cnt_t'(1);
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== hw/ring_gw_demux.sv ====
// Wormhole router behind the ring input buffer.
// The first flit of a packet picks the way: to the local port when its
// destination matches node_id, onward on the ring otherwise. Later flits
// follow the same way until the last flit has transferred.
// Combinational data path, state moves on the transfer edge.

`timescale 1ns/1ps
`include "ring_gw_settings.svh"

module ring_gw_demux import ring_gw_pkg::*; #(
  parameter node_id_t node_id = '0
) (
  input  logic  clk,
  input  logic  rst,

  input  flit_t in_flit,
  input  logic  in_valid,
  output logic  in_ready,

  output flit_t local_flit,
  output logic  local_valid,
  input  logic  local_ready,

  output flit_t pass_flit,
  output logic  pass_valid,
  input  logic  pass_ready
);

  route_state_t state;
  route_state_t state_nxt;
  node_id_t     dest;
  logic         to_local;
  logic         xfer;

  // Destination sits in the top bits, only meaningful on a first flit
  assign dest = in_flit.data[`RING_FLIT_WIDTH-1 -: `RING_DEST_WIDTH];

  // Both outputs see the flit, valid decides who takes it
  assign local_flit = in_flit;
  assign pass_flit  = in_flit;

  ////////////////////////////////////////////////////////////////////////////
  // Steering
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_nxt = state;
    case (state)
      route_idle:  to_local = (dest == node_id);
      route_local: to_local = 1'b1;
      default:     to_local = 1'b0;
    endcase

    local_valid = in_valid && to_local;
    pass_valid  = in_valid && !to_local;
    // Stall follows the chosen output only
    in_ready    = to_local ? local_ready : pass_ready;
    xfer        = in_valid && in_ready;

    // Single flit packets never leave idle
    if (xfer) begin
      if (in_flit.last) begin
        state_nxt = route_idle;
      end else if (state == route_idle) begin
        state_nxt = to_local ? route_local : route_pass;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= route_idle;
    end else begin
      state <= state_nxt;
    end
  end

endmodule

// ==== hw/ring_gw_mux.sv ====
// Wormhole arbiter onto the ring output.
// Merges packets passing through, packets from the local port and
// packets from the external port. A free output goes to the ring first,
// then local, then external. The winner keeps the output until its last
// flit has gone, so packets never interleave.

`timescale 1ns/1ps
`include "ring_gw_settings.svh"

module ring_gw_mux import ring_gw_pkg::*; (
  input  logic  clk,
  input  logic  rst,

  input  flit_t ring_flit,
  input  logic  ring_valid,
  output logic  ring_ready,

  input  flit_t local_flit,
  input  logic  local_valid,
  output logic  local_ready,

  input  flit_t ext_flit,
  input  logic  ext_valid,
  output logic  ext_ready,

  output flit_t out_flit,
  output logic  out_valid,
  input  logic  out_ready
);

  worm_state_t state;
  worm_state_t state_nxt;
  worm_state_t grant;
  logic        xfer;

  ////////////////////////////////////////////////////////////////////////////
  // Grant
  ////////////////////////////////////////////////////////////////////////////

  // Locked worm keeps its source, idle picks by priority
  always_comb begin
    grant = state;
    if (state == worm_idle) begin
      if (ring_valid) begin
        grant = worm_ring;
      end else if (local_valid) begin
        grant = worm_local;
      end else if (ext_valid) begin
        grant = worm_ext;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Output select
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    out_flit    = ring_flit;
    out_valid   = 1'b0;
    ring_ready  = 1'b0;
    local_ready = 1'b0;
    ext_ready   = 1'b0;
    case (grant)
      worm_ring: begin
        out_flit   = ring_flit;
        out_valid  = ring_valid;
        ring_ready = out_ready;
      end
      worm_local: begin
        out_flit    = local_flit;
        out_valid   = local_valid;
        local_ready = out_ready;
      end
      worm_ext: begin
        out_flit  = ext_flit;
        out_valid = ext_valid;
        ext_ready = out_ready;
      end
      // Nothing offered, all readies low
      default: ;
    endcase
  end

  assign xfer = out_valid && out_ready;

  // Hold the grant past a non-last flit, release on the last one
  always_comb begin
    state_nxt = state;
    if (xfer) begin
      state_nxt = out_flit.last ? worm_idle : grant;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= worm_idle;
    end else begin
      state <= state_nxt;
    end
  end

endmodule

// ==== hw/ring_gateway.sv ====
// Gateway of one ring node.
// Ring flits pass the input buffer, then the router, which hands local
// packets to local_out and the rest to the arbiter. The arbiter merges
// them with local_in and ext_in onto ring_out.
// Set node_id to the address of this node.

`timescale 1ns/1ps
`include "ring_gw_settings.svh"

module ring_gateway import ring_gw_pkg::*; #(
  parameter node_id_t node_id = '0
) (
  input  logic  clk,
  input  logic  rst,

  input  flit_t ring_in_flit,
  input  logic  ring_in_valid,
  output logic  ring_in_ready,

  output flit_t ring_out_flit,
  output logic  ring_out_valid,
  input  logic  ring_out_ready,

  input  flit_t local_in_flit,
  input  logic  local_in_valid,
  output logic  local_in_ready,

  output flit_t local_out_flit,
  output logic  local_out_valid,
  input  logic  local_out_ready,

  input  flit_t ext_in_flit,
  input  logic  ext_in_valid,
  output logic  ext_in_ready
);

  // Buffer to router
  flit_t buf_flit;
  logic  buf_valid;
  logic  buf_ready;

  // Router to arbiter, packets passing through
  flit_t pass_flit;
  logic  pass_valid;
  logic  pass_ready;

  ////////////////////////////////////////////////////////////////////////////
  // Ring input path
  ////////////////////////////////////////////////////////////////////////////

  flit_fifo #(
    .depth (`GW_FIFO_DEPTH)
  ) u_in_buf (
    .clk       (clk),
    .rst       (rst),
    .in_flit   (ring_in_flit),
    .in_valid  (ring_in_valid),
    .in_ready  (ring_in_ready),
    .out_flit  (buf_flit),
    .out_valid (buf_valid),
    .out_ready (buf_ready)
  );

  ring_gw_demux #(
    .node_id (node_id)
  ) u_route (
    .clk         (clk),
    .rst         (rst),
    .in_flit     (buf_flit),
    .in_valid    (buf_valid),
    .in_ready    (buf_ready),
    .local_flit  (local_out_flit),
    .local_valid (local_out_valid),
    .local_ready (local_out_ready),
    .pass_flit   (pass_flit),
    .pass_valid  (pass_valid),
    .pass_ready  (pass_ready)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Ring output merge
  ////////////////////////////////////////////////////////////////////////////

  ring_gw_mux u_arb (
    .clk         (clk),
    .rst         (rst),
    .ring_flit   (pass_flit),
    .ring_valid  (pass_valid),
    .ring_ready  (pass_ready),
    .local_flit  (local_in_flit),
    .local_valid (local_in_valid),
    .local_ready (local_in_ready),
    .ext_flit    (ext_in_flit),
    .ext_valid   (ext_in_valid),
    .ext_ready   (ext_in_ready),
    .out_flit    (ring_out_flit),
    .out_valid   (ring_out_valid),
    .out_ready   (ring_out_ready)
  );

endmodule

// ==== bench/ring_gateway_assert.sv ====
// Protocol checks on the ring output arbiter.
// Bound into every ring_gw_mux instance. A failing property reports
// with $error and bumps fail_count, which the testbench reads at the end.

`timescale 1ns/1ps

module ring_gateway_assert import ring_gw_pkg::*; (
  input logic        clk,
  input logic        rst,
  input flit_t       out_flit,
  input logic        out_valid,
  input logic        out_ready,
  input logic        ring_valid,
  input logic        local_valid,
  input logic        ring_ready,
  input logic        local_ready,
  input logic        ext_ready,
  input worm_state_t state,
  input worm_state_t grant
);

  int fail_count = 0;

  // Stalled flit and valid hold while a worm owns the output
  a_stall_hold: assert property (@(posedge clk) disable iff (rst)
    out_valid && !out_ready && state != worm_idle |=> out_valid && $stable(out_flit))
  else begin
    fail_count++;
    $error("ring_out flit or valid changed under stall");
  end

  // Owner holds from a non-last transfer until the last flit goes
  a_grant_hold: assert property (@(posedge clk) disable iff (rst)
    (state != worm_idle || (out_valid && out_ready)) &&
    !(out_valid && out_ready && out_flit.last) |=> grant == $past(grant))
  else begin
    fail_count++;
    $error("arbiter grant changed inside a packet");
  end

  // At most one ready, and it belongs to the locked worm or to the
  // highest priority offer of an idle output
  a_ready_grant: assert property (@(posedge clk) disable iff (rst)
    $onehot0({ring_ready, local_ready, ext_ready}) &&
    !(ring_ready && state != worm_idle && state != worm_ring) &&
    !(local_ready && (state == worm_idle ? ring_valid : state != worm_local)) &&
    !(ext_ready && (state == worm_idle ? (ring_valid || local_valid) : state != worm_ext)))
  else begin
    fail_count++;
    $error("ready high on an ungranted source");
  end

endmodule

bind ring_gw_mux ring_gateway_assert u_mux_chk (
  .clk         (clk),
  .rst         (rst),
  .out_flit    (out_flit),
  .out_valid   (out_valid),
  .out_ready   (out_ready),
  .ring_valid  (ring_valid),
  .local_valid (local_valid),
  .ring_ready  (ring_ready),
  .local_ready (local_ready),
  .ext_ready   (ext_ready),
  .state       (state),
  .grant       (grant)
);

// ==== bench/ring_gateway_tb.sv ====
// Directed testbench for the ring gateway.
// Drives ring_in, local_in and ext_in, collects ring_out and local_out,
// and compares every flit with queues built from the routing rule and
// the no-interleave rule. Stops at the first mismatch or timeout.

`timescale 1ns/1ps
`include "ring_gw_settings.svh"

module ring_gateway_tb import ring_gw_pkg::*; ();

  typedef flit_t pkt_t[$];

  localparam node_id_t self_node  = node_id_t'(5);
  localparam node_id_t other_node = node_id_t'(9);
  localparam int timeout_cycles = 1000;
  // Source tag, three bits right below the destination field
  localparam int tag_msb    = `RING_FLIT_WIDTH - `RING_DEST_WIDTH - 1;
  localparam int port_ring  = 0;
  localparam int port_local = 1;
  localparam int port_ext   = 2;

  logic   clk;
  logic   rst;
  flit_t  ring_in_flit;
  logic   ring_in_valid;
  logic   ring_in_ready;
  flit_t  ring_out_flit;
  logic   ring_out_valid;
  logic   ring_out_ready;
  flit_t  local_in_flit;
  logic   local_in_valid;
  logic   local_in_ready;
  flit_t  local_out_flit;
  logic   local_out_valid;
  logic   local_out_ready;
  flit_t  ext_in_flit;
  logic   ext_in_valid;
  logic   ext_in_ready;
  integer seed;
  logic   traffic_done;
  int     ring_out_xfers = 0;
  int     local_out_xfers = 0;

  // Expected flits per source, in send order
  pkt_t exp_pass;
  pkt_t exp_loc_out;
  pkt_t exp_from_local;
  pkt_t exp_from_ext;

  ring_gateway #(
    .node_id (self_node)
  ) u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Transfer counts, to catch leaked or duplicated flits
  always @(posedge clk) begin
    if (ring_out_valid && ring_out_ready) begin
      ring_out_xfers <= ring_out_xfers + 1;
    end
    if (local_out_valid && local_out_ready) begin
      local_out_xfers <= local_out_xfers + 1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reporting and compare
  ////////////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_flit(input flit_t got, input flit_t exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("error at %0t: %s flit %h last %b, expected %h last %b",
                          $time, what, got.data, got.last, exp.data, exp.last));
    end
  endtask

  task automatic check_dest(input node_id_t got, input node_id_t exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("error at %0t: %s node %0d, expected %0d", $time, what, got, exp));
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("error at %0t: %s is %b, expected %b", $time, what, got, exp));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stream driver and receivers
  ////////////////////////////////////////////////////////////////////////////

  // Random payload, then destination and source tag on top
  function automatic pkt_t make_pkt(input int port, input node_id_t dest, input int len);
    pkt_t  p;
    flit_t f;
    for (int i = 0; i < len; i++) begin
      f.data = flit_data_t'($random(seed));
      f.data[`RING_FLIT_WIDTH-1 -: `RING_DEST_WIDTH] = dest;
      f.data[tag_msb -: 3] = 3'(port + 1);
      f.last = (i == len - 1);
      p.push_back(f);
    end
    return p;
  endfunction

  task automatic drive_port(input int port, input flit_t f, input logic v);
    case (port)
      port_ring: begin
        ring_in_flit  = f;
        ring_in_valid = v;
      end
      port_local: begin
        local_in_flit  = f;
        local_in_valid = v;
      end
      default: begin
        ext_in_flit  = f;
        ext_in_valid = v;
      end
    endcase
  endtask

  function automatic logic port_ready(input int port);
    case (port)
      port_ring:  return ring_in_ready;
      port_local: return local_in_ready;
      default:    return ext_in_ready;
    endcase
  endfunction

  // Flits back to back, each held until accepted
  task automatic send_pkt(input int port, input pkt_t pkt);
    int cycles;
    @(negedge clk);
    foreach (pkt[i]) begin
      drive_port(port, pkt[i], 1'b1);
      cycles = 0;
      @(posedge clk);
      while (!port_ready(port)) begin
        cycles++;
        if (cycles > timeout_cycles) begin
          abort_run("timeout waiting for an input port to accept a flit");
        end
        @(posedge clk);
      end
      @(negedge clk);
    end
    drive_port(port, '0, 1'b0);
  endtask

  task automatic wait_out(input logic to_local, output flit_t f);
    int cycles;
    cycles = 0;
    @(posedge clk);
    while (to_local ? !(local_out_valid && local_out_ready)
                    : !(ring_out_valid && ring_out_ready)) begin
      cycles++;
      if (cycles > timeout_cycles) begin
        abort_run(to_local ? "timeout waiting for a flit on local_out"
                           : "timeout waiting for a flit on ring_out");
      end
      @(posedge clk);
    end
    f = to_local ? local_out_flit : ring_out_flit;
  endtask

  task automatic expect_out(input logic to_local, input pkt_t pkt);
    flit_t f;
    foreach (pkt[i]) begin
      wait_out(to_local, f);
      // Only the own address may reach the local port
      if (to_local && i == 0) begin
        check_dest(f.data[`RING_FLIT_WIDTH-1 -: `RING_DEST_WIDTH], self_node,
                   "local_out destination");
      end
      check_flit(f, pkt[i], to_local ? "local_out" : "ring_out");
    end
  endtask

  // Source picked by the tag of a first flit, kept until last
  task automatic drain_ring(input int n);
    flit_t f;
    flit_t e;
    int    src;
    logic  in_pkt;
    in_pkt = 1'b0;
    src = 0;
    repeat (n) begin
      wait_out(1'b0, f);
      if (!in_pkt) begin
        src = int'(f.data[tag_msb -: 3]);
      end
      if (src == port_ring + 1 && exp_pass.size() > 0) begin
        e = exp_pass.pop_front();
      end else if (src == port_local + 1 && exp_from_local.size() > 0) begin
        e = exp_from_local.pop_front();
      end else if (src == port_ext + 1 && exp_from_ext.size() > 0) begin
        e = exp_from_ext.pop_front();
      end else begin
        abort_run("ring_out carried a flit that no source had pending");
      end
      check_flit(f, e, "ring_out");
      in_pkt = !f.last;
    end
  endtask

  task automatic drain_local(input int n);
    flit_t f;
    repeat (n) begin
      wait_out(1'b1, f);
      check_flit(f, exp_loc_out.pop_front(), "local_out");
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_idle_outputs();
    check_bit(ring_out_valid, 1'b0, "ring_out_valid");
    check_bit(local_out_valid, 1'b0, "local_out_valid");
    check_bit(ring_in_ready, 1'b1, "ring_in_ready");
  endtask

  task automatic test_reset();
    rst = 1'b1;
    @(posedge clk);
    repeat (15) begin
      @(posedge clk);
      check_idle_outputs();
    end
    @(negedge clk);
    rst = 1'b0;
    @(posedge clk);
    check_idle_outputs();
  endtask

  task automatic test_local_delivery();
    pkt_t p;
    int   ring_before;
    p = make_pkt(port_ring, self_node, 3);
    ring_before = ring_out_xfers;
    fork
      send_pkt(port_ring, p);
      expect_out(1'b1, p);
    join
    repeat (4) @(posedge clk);
    if (ring_out_xfers != ring_before) begin
      abort_run("a packet for this node also showed up on ring_out");
    end
  endtask

  task automatic test_pass_through();
    pkt_t p_long;
    pkt_t p_one;
    int   local_before;
    p_long = make_pkt(port_ring, other_node, 3);
    p_one  = make_pkt(port_ring, other_node, 1);
    local_before = local_out_xfers;
    fork
      begin
        send_pkt(port_ring, p_long);
        send_pkt(port_ring, p_one);
      end
      begin
        expect_out(1'b0, p_long);
        expect_out(1'b0, p_one);
      end
    join
    repeat (4) @(posedge clk);
    if (local_out_xfers != local_before) begin
      abort_run("a passing packet also showed up on local_out");
    end
  endtask

  // Same cycle offer, local wins and goes out whole
  task automatic test_priority();
    pkt_t p_loc;
    pkt_t p_ext;
    p_loc = make_pkt(port_local, other_node, 2);
    p_ext = make_pkt(port_ext, other_node, 3);
    fork
      send_pkt(port_local, p_loc);
      send_pkt(port_ext, p_ext);
      begin
        expect_out(1'b0, p_loc);
        expect_out(1'b0, p_ext);
      end
    join
  endtask

  task automatic test_back_pressure();
    pkt_t     ring_stream;
    pkt_t     local_stream;
    pkt_t     ext_stream;
    pkt_t     p;
    node_id_t dest;
    int       n_ring;
    int       n_local;
    int       ring_before;
    int       local_before;
    for (int k = 0; k < 6; k++) begin
      dest = (($random(seed) & 1) == 0) ? self_node : other_node;
      p = make_pkt(port_ring, dest, 1 + ($random(seed) & 3));
      foreach (p[i]) begin
        ring_stream.push_back(p[i]);
        // Own address goes local, the rest passes
        if (dest == self_node) begin
          exp_loc_out.push_back(p[i]);
        end else begin
          exp_pass.push_back(p[i]);
        end
      end
      p = make_pkt(port_local, other_node, 1 + ($random(seed) & 3));
      foreach (p[i]) local_stream.push_back(p[i]);
      p = make_pkt(port_ext, other_node, 1 + ($random(seed) & 3));
      foreach (p[i]) ext_stream.push_back(p[i]);
    end
    exp_from_local = local_stream;
    exp_from_ext   = ext_stream;
    n_ring  = exp_pass.size() + local_stream.size() + ext_stream.size();
    n_local = exp_loc_out.size();
    ring_before  = ring_out_xfers;
    local_before = local_out_xfers;
    traffic_done = 1'b0;
    fork
      send_pkt(port_ring, ring_stream);
      send_pkt(port_local, local_stream);
      send_pkt(port_ext, ext_stream);
      begin
        fork
          drain_ring(n_ring);
          drain_local(n_local);
        join
        traffic_done = 1'b1;
      end
      // Random stalls on both outputs, ready three times in four
      while (!traffic_done) begin
        @(negedge clk);
        ring_out_ready  = ($random(seed) & 3) != 0;
        local_out_ready = ($random(seed) & 3) != 0;
      end
    join
    ring_out_ready  = 1'b1;
    local_out_ready = 1'b1;
    repeat (8) @(posedge clk);
    if (ring_out_xfers - ring_before != n_ring ||
        local_out_xfers - local_before != n_local) begin
      abort_run("more flits came out than were sent");
    end
  endtask

  initial begin
    seed            = 32'hae89;
    traffic_done    = 1'b0;
    rst             = 1'b1;
    ring_in_flit    = '0;
    ring_in_valid   = 1'b0;
    local_in_flit   = '0;
    local_in_valid  = 1'b0;
    ext_in_flit     = '0;
    ext_in_valid    = 1'b0;
    ring_out_ready  = 1'b1;
    local_out_ready = 1'b1;
    test_reset();
    test_local_delivery();
    test_pass_through();
    test_priority();
    test_back_pressure();
    repeat (4) @(posedge clk);
    if (u_dut.u_arb.u_mux_chk.fail_count != 0) begin
      abort_run("arbiter assertions failed during the run");
    end else begin
      $display("*** TEST PASSED ***");
      $finish;
    end
  end

endmodule

// ==== tb.f ====
+incdir+hw
hw/ring_gw_pkg.sv
hw/flit_fifo.sv
hw/ring_gw_demux.sv
hw/ring_gw_mux.sv
hw/ring_gateway.sv
bench/ring_gateway_assert.sv
bench/ring_gateway_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the ring gateway testbench with Verilator and run it.
# Exit status is zero only when the pass message appears in the output.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module ring_gateway_tb -f tb.f \
  || { echo "run_sim: verilator build failed"; exit 1; }
out=$(./obj_dir/Vring_gateway_tb +verilator+error+limit+100)
echo "$out"
echo "$out" | grep -qF '*** TEST PASSED ***' && echo "run_sim: pass" \
  || { echo "run_sim: fail"; exit 1; }
